//--- src.f
rtl/mipsPkg.sv
rtl/controller.sv
rtl/alu.sv
rtl/regFile.sv
rtl/memAccess.sv
rtl/mipsCore.sv
tb/tbMipsCore.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tbMipsCore -f src.f -o simMips
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

out=$(./obj_dir/simMips)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

//--- tb/tbMipsCore.sv
`timescale 1ns/1ns

module tbMipsCore import mipsPkg::*; ();

    logic        clk  = 1'b0;
    logic        rstN = 1'b0;
    logic [31:0] imemAddr;
    logic [31:0] imemData;
    wbReqT       wbReq;
    wbRspT       wbRsp = '0;

    // program table
    logic [31:0] progTab [40][7];
    logic [31:0] initTab [40];
    logic [31:0] adrTab [40];
    logic [3:0]  selTab [40];
    logic [31:0] datTab [40];
    int          progCount = 0;

    logic [31:0] rom [256] = '{default: 32'h0};
    logic [31:0] mem [256];
    logic [31:0] curInit = '0;
    logic        useDelay = 1'b0;

    // bus model state
    logic [31:0] lfsr = 32'h52b6_1a17;
    logic        armed = 1'b0;
    logic [1:0]  delayLeft = '0;
    logic        bit0;
    logic        bit1;
    logic        holdValid = 1'b0;
    logic [31:0] heldAdr = '0;
    logic [31:0] lastAdr = '0;
    logic [3:0]  lastSel = '0;
    logic [31:0] lastDat = '0;
    int          storeCount = 0;

    int valueErrors = 0;
    int busErrors = 0;
    int timeoutErrors = 0;

    mipsCore dut (
        .clk      (clk),
        .rstN     (rstN),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .wbReq    (wbReq),
        .wbRsp    (wbRsp)
    );

    always #4 clk = ~clk;

    assign imemData = (imemAddr[31:10] == '0) ? rom[imemAddr[9:2]] : 32'h0;

    ////////////////////////////////////////////////////////////
    // instruction encoders
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] rType(funcE f, int rs, int rt, int rd, int sh);
        return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(sh), f};
    endfunction

    function automatic logic [31:0] iType(opcodeE op, int rs, int rt, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [31:0] jType(opcodeE op, int wordIdx);
        return {op, 26'(wordIdx)};
    endfunction

    function automatic logic [31:0] storeOut(int rt);
        return iType(OP_SW, 0, rt, 32'h40);
    endfunction

    // branch to itself, parks the core
    function automatic logic [31:0] parkLoop();
        return iType(OP_BEQ, 0, 0, -1);
    endfunction

    function automatic logic [31:0] stepLfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    ////////////////////////////////////////////////////////////
    // wishbone memory model
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        // an ack seen at the last edge closed that access
        if (wbRsp.ack) begin
            armed = 1'b0;
        end
        if (!wbReq.cyc || !wbReq.stb) begin
            wbRsp = '0;
            armed = 1'b0;
        end else begin
            if (!armed) begin
                armed = 1'b1;
                bit0 = lfsr[0];
                lfsr = stepLfsr(lfsr);
                bit1 = lfsr[0];
                lfsr = stepLfsr(lfsr);
                delayLeft = useDelay ? {bit1, bit0} : 2'd0;
            end else if (delayLeft != 2'd0) begin
                delayLeft = delayLeft - 2'd1;
            end
            wbRsp.ack  = (delayLeft == 2'd0);
            wbRsp.datR = (delayLeft == 2'd0) ? mem[wbReq.adr[9:2]] : 32'h0;
        end
    end

    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] = 32'h9E37_79B9 * 32'(i + 1);
            end
            mem[4] = curInit;
            holdValid = 1'b0;
        end else begin
            if (holdValid && wbReq.stb) begin
                assert (wbReq.adr === heldAdr) else begin
                    busErrors++;
                    $display("[FAIL] wbReq.adr expected %h got %h", heldAdr, wbReq.adr);
                end
            end
            holdValid = wbReq.stb && !wbRsp.ack;
            heldAdr   = wbReq.adr;
            if (wbReq.cyc && wbReq.stb && wbRsp.ack && wbReq.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (wbReq.sel[b]) begin
                        mem[wbReq.adr[9:2]][8*b +: 8] = wbReq.datW[8*b +: 8];
                    end
                end
                lastAdr = wbReq.adr;
                lastSel = wbReq.sel;
                lastDat = wbReq.datW;
                storeCount++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // table building
    ////////////////////////////////////////////////////////////

    task automatic addProg(input logic [31:0] w0, w1, w2, w3, w4, w5, w6,
                           input logic [31:0] init, adr, input logic [3:0] sel,
                           input logic [31:0] dat);
        progTab[progCount] = '{w0, w1, w2, w3, w4, w5, w6};
        initTab[progCount] = init;
        adrTab[progCount]  = adr;
        selTab[progCount]  = sel;
        datTab[progCount]  = dat;
        progCount++;
    endtask

    // marker 0x22 when the branch skips, 0x33 when it falls through
    task automatic addBranch(input logic [31:0] br, input int x, y,
                             input logic [31:0] marker);
        addProg(iType(OP_ADDI, 0, 1, x), iType(OP_ADDI, 0, 2, y), br,
                iType(OP_ADDI, 0, 3, 32'h11), iType(OP_ADDI, 3, 3, 32'h22),
                storeOut(3), parkLoop(), 32'h0, 32'h40, 4'hF, marker);
    endtask

    // two operands from ori, one R-type op into $3
    task automatic addLogic(input funcE f, input logic [31:0] dat);
        addProg(iType(OP_ORI, 0, 1, 32'hF0F0), iType(OP_ORI, 0, 2, 32'hFF00),
                rType(f, 1, 2, 3, 0), storeOut(3), parkLoop(), 0, 0,
                32'h0, 32'h40, 4'hF, dat);
    endtask

    task automatic buildTable();
        logic [31:0] lp;
        lp = parkLoop();
        addProg(iType(OP_ADDI, 0, 1, 5), iType(OP_ADDI, 0, 2, -3), rType(F_ADD, 1, 2, 3, 0),
                storeOut(3), lp, 0, 0, 32'h0, 32'h40, 4'hF, 32'h0000_0002);
        addProg(iType(OP_ADDI, 0, 1, 5), iType(OP_ADDI, 0, 2, 7), rType(F_SUB, 1, 2, 3, 0),
                storeOut(3), lp, 0, 0, 32'h0, 32'h40, 4'hF, 32'hFFFF_FFFE);
        addProg(iType(OP_ADDI, 0, 1, -6), iType(OP_ADDI, 0, 2, 1000),
                rType(F_MUL, 1, 2, 3, 0), storeOut(3), lp, 0, 0,
                32'h0, 32'h40, 4'hF, 32'hFFFF_E890);
        addLogic(F_AND, 32'h0000_F000);
        addLogic(F_OR, 32'h0000_FFF0);
        addLogic(F_NOR, 32'hFFFF_000F);
        addLogic(F_XOR, 32'h0000_0FF0);
        addProg(iType(OP_ORI, 0, 1, 32'h8001), rType(F_SLL, 0, 1, 3, 4), storeOut(3), lp,
                0, 0, 0, 32'h0, 32'h40, 4'hF, 32'h0008_0010);
        addProg(iType(OP_ADDI, 0, 1, -16), rType(F_SRL, 0, 1, 3, 4), storeOut(3), lp,
                0, 0, 0, 32'h0, 32'h40, 4'hF, 32'h0FFF_FFFF);
        addProg(iType(OP_ADDI, 0, 1, -1), iType(OP_ADDI, 0, 2, 1), rType(F_SLT, 1, 2, 3, 0),
                storeOut(3), lp, 0, 0, 32'h0, 32'h40, 4'hF, 32'h0000_0001);
        // slti sign extends, andi and xori zero extend
        addProg(iType(OP_ADDI, 0, 1, -5), iType(OP_SLTI, 1, 2, -6),
                iType(OP_ANDI, 1, 3, 32'hFFFF), iType(OP_XORI, 3, 4, 32'h80FF),
                rType(F_ADD, 2, 4, 5, 0), storeOut(5), lp,
                32'h0, 32'h40, 4'hF, 32'h0000_7F04);
        // sub-word stores and loads
        addProg(iType(OP_ADDI, 0, 1, 32'h1A7), iType(OP_SB, 0, 1, 32'h43), lp,
                0, 0, 0, 0, 32'h0, 32'h40, 4'b1000, 32'hA7A7_A7A7);
        addProg(iType(OP_ADDI, 0, 1, -2), iType(OP_SH, 0, 1, 32'h42), lp,
                0, 0, 0, 0, 32'h0, 32'h40, 4'b1100, 32'hFFFE_FFFE);
        addProg(iType(OP_LB, 0, 1, 32'h12), storeOut(1), lp, 0, 0, 0, 0,
                32'h80C3_7F12, 32'h40, 4'hF, 32'hFFFF_FFC3);
        addProg(iType(OP_LH, 0, 1, 32'h12), storeOut(1), lp, 0, 0, 0, 0,
                32'h80C3_7F12, 32'h40, 4'hF, 32'hFFFF_80C3);
        addProg(iType(OP_LW, 0, 1, 32'h10), storeOut(1), lp, 0, 0, 0, 0,
                32'h80C3_7F12, 32'h40, 4'hF, 32'h80C3_7F12);
        // each branch taken, then not taken
        addBranch(iType(OP_BEQ, 1, 2, 1), 5, 5, 32'h22);
        addBranch(iType(OP_BEQ, 1, 2, 1), 5, 6, 32'h33);
        addBranch(iType(OP_BNE, 1, 2, 1), 5, 6, 32'h22);
        addBranch(iType(OP_BNE, 1, 2, 1), 5, 5, 32'h33);
        addBranch(iType(OP_BLEZ, 1, 0, 1), 0, 0, 32'h22);
        addBranch(iType(OP_BLEZ, 1, 0, 1), 3, 0, 32'h33);
        addBranch(iType(OP_BGTZ, 1, 0, 1), 3, 0, 32'h22);
        addBranch(iType(OP_BGTZ, 1, 0, 1), 0, 0, 32'h33);
        addBranch(iType(OP_REGIMM, 1, 0, 1), -1, 0, 32'h22);
        addBranch(iType(OP_REGIMM, 1, 0, 1), 0, 0, 32'h33);
        addBranch(iType(OP_REGIMM, 1, 1, 1), 0, 0, 32'h22);
        addBranch(iType(OP_REGIMM, 1, 1, 1), -1, 0, 32'h33);
        // jumps
        addProg(jType(OP_J, 3), iType(OP_ADDI, 0, 3, 32'h11), iType(OP_ADDI, 0, 3, 32'h11),
                iType(OP_ADDI, 3, 3, 32'h22), storeOut(3), lp, 0,
                32'h0, 32'h40, 4'hF, 32'h22);
        addProg(iType(OP_ADDI, 0, 1, 12), rType(F_JR, 1, 0, 0, 0),
                iType(OP_ADDI, 0, 3, 32'h11), iType(OP_ADDI, 3, 3, 32'h22), storeOut(3), lp,
                0, 32'h0, 32'h40, 4'hF, 32'h22);
        // jal sits at address 4, so $31 gets 8
        addProg(iType(OP_ADDI, 0, 1, 0), jType(OP_JAL, 3), iType(OP_ADDI, 0, 31, 32'h55),
                storeOut(31), lp, 0, 0, 32'h0, 32'h40, 4'hF, 32'h0000_0008);
        // unknown opcode 0x3f falls through
        addProg(iType(OP_ADDI, 0, 3, 32'h11), 32'hFC00_0000, iType(OP_ADDI, 3, 3, 32'h22),
                storeOut(3), lp, 0, 0, 32'h0, 32'h40, 4'hF, 32'h33);
    endtask

    ////////////////////////////////////////////////////////////
    // run and check
    ////////////////////////////////////////////////////////////

    task automatic checkValue(input string name, input logic [31:0] exp, got);
        assert (got === exp) else begin
            valueErrors++;
            $display("[FAIL] %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic runProg(input int n);
        int cycles;
        int startCount;
        @(negedge clk);
        rstN = 1'b0;
        curInit = initTab[n];
        for (int i = 0; i < 256; i++) begin
            rom[i] = (i < 7) ? progTab[n][i] : 32'h0;
        end
        repeat (3) @(negedge clk);
        checkValue("wbReq.cyc", 32'h0, {31'd0, wbReq.cyc});
        checkValue("wbReq.stb", 32'h0, {31'd0, wbReq.stb});
        checkValue("imemAddr", RESET_PC, imemAddr);
        startCount = storeCount;
        rstN = 1'b1;
        cycles = 0;
        while (storeCount == startCount && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        assert (storeCount != startCount) else begin
            timeoutErrors++;
            $display("program %0d made no store within 200 cycles", n);
        end
        if (storeCount != startCount) begin
            checkValue("wbReq.adr", adrTab[n], lastAdr);
            checkValue("wbReq.sel", {28'd0, selTab[n]}, {28'd0, lastSel});
            checkValue("wbReq.datW", datTab[n], lastDat);
        end
    endtask

    initial begin
        buildTable();
        // first pass acks at once, second with random delays
        for (int pass = 0; pass < 2; pass++) begin
            useDelay = (pass == 1);
            for (int n = 0; n < progCount; n++) begin
                runProg(n);
            end
        end
        $display("errors: %0d value, %0d bus, %0d timeout",
                 valueErrors, busErrors, timeoutErrors);
        if (valueErrors + busErrors + timeoutErrors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- rtl/mipsCore.sv
`timescale 1ns/1ns

module mipsCore import mipsPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    output logic [31:0] imemAddr,
    input  logic [31:0] imemData,
    output wbReqT       wbReq,
    input  wbRspT       wbRsp
);

    ctrlT            ctrl;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pcPlus4;
    logic [XLEN-1:0] nextPc;
    logic [XLEN-1:0] branchTarget;
    logic [XLEN-1:0] jumpTarget;
    logic [XLEN-1:0] immSext;
    logic [XLEN-1:0] immVal;
    logic [XLEN-1:0] rsData;
    logic [XLEN-1:0] rtData;
    logic [XLEN-1:0] aluB;
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] loadData;
    logic [XLEN-1:0] wData;
    logic [4:0]      shiftAmt;
    logic [4:0]      wAddr;
    logic            aluZero;
    logic            negA;
    logic            zeroA;
    logic            takeBranch;
    logic            memDone;
    logic            stall;
    logic            regWe;

    assign imemAddr = pc;
    assign pcPlus4  = pc + 32'd4;

    controller uCtrl (
        .op   (imemData[31:26]),
        .func (imemData[5:0]),
        .rt   (imemData[20:16]),
        .ctrl (ctrl)
    );

    ////////////////////////////////////////////////////////////
    // operands and execute
    ////////////////////////////////////////////////////////////

    assign immSext = {{16{imemData[15]}}, imemData[15:0]};
    assign immVal  = (ctrl.immExt == EXT_ZERO) ? {16'h0000, imemData[15:0]} : immSext;
    assign aluB    = ctrl.aluSrcImm ? immVal : rtData;
    // variable shifts would take rs, not decoded here
    assign shiftAmt = ctrl.shiftByShamt ? imemData[10:6] : rsData[4:0];

    alu uAlu (
        .a      (rsData),
        .b      (aluB),
        .shamt  (shiftAmt),
        .aluOp  (ctrl.aluOp),
        .result (aluResult),
        .zero   (aluZero),
        .negA   (negA),
        .zeroA  (zeroA)
    );

    memAccess uMem (
        .clk       (clk),
        .rstN      (rstN),
        .ctrl      (ctrl),
        .addr      (aluResult),
        .storeData (rtData),
        .loadData  (loadData),
        .done      (memDone),
        .wbReq     (wbReq),
        .wbRsp     (wbRsp)
    );

    // hold everything until the bus acks
    assign stall = (ctrl.memRead | ctrl.memWrite) & ~memDone;

    ////////////////////////////////////////////////////////////
    // writeback
    ////////////////////////////////////////////////////////////

    assign wAddr = ctrl.link   ? 5'(LINK_REG) :
                   ctrl.regDst ? imemData[15:11] : imemData[20:16];
    assign wData = ctrl.link     ? pcPlus4  :
                   ctrl.memToReg ? loadData : aluResult;
    assign regWe = ctrl.regWrite & ~ctrl.illegal & ~stall;

    regFile uRegs (
        .clk    (clk),
        .rstN   (rstN),
        .rs     (imemData[25:21]),
        .rt     (imemData[20:16]),
        .rsData (rsData),
        .rtData (rtData),
        .we     (regWe),
        .wAddr  (wAddr),
        .wData  (wData)
    );

    ////////////////////////////////////////////////////////////
    // next pc
    ////////////////////////////////////////////////////////////

    assign branchTarget = pcPlus4 + {immSext[XLEN-3:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], imemData[25:0], 2'b00};

    always_comb begin
        case (ctrl.branch)
            BR_EQ:   takeBranch = aluZero;
            BR_NE:   takeBranch = ~aluZero;
            BR_GTZ:  takeBranch = ~negA & ~zeroA;
            BR_LEZ:  takeBranch = negA | zeroA;
            BR_GEZ:  takeBranch = ~negA;
            BR_LTZ:  takeBranch = negA;
            default: takeBranch = 1'b0;
        endcase
    end

    always_comb begin
        case (ctrl.jump)
            JMP_TARGET: nextPc = jumpTarget;
            JMP_REG:    nextPc = rsData;
            default:    nextPc = takeBranch ? branchTarget : pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= RESET_PC;
        end else if (!stall) begin
            pc <= nextPc;
        end
    end

endmodule

//--- rtl/memAccess.sv
`timescale 1ns/1ns

module memAccess import mipsPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  ctrlT        ctrl,
    input  logic [31:0] addr,
    input  logic [31:0] storeData,
    output logic [31:0] loadData,
    output logic        done,
    output wbReqT       wbReq,
    input  wbRspT       wbRsp
);

    typedef enum logic {IDLE, WAIT} stateE;

    stateE state;
    wbReqT freshReq;
    wbReqT reqQ;
    logic  memOp;

    assign memOp = ctrl.memRead | ctrl.memWrite;

    ////////////////////////////////////////////////////////////
    // request from the decoded instruction
    ////////////////////////////////////////////////////////////

    always_comb begin
        freshReq     = '0;
        freshReq.cyc = 1'b1;
        freshReq.stb = 1'b1;
        freshReq.we  = ctrl.memWrite;
        freshReq.adr = {addr[31:2], 2'b00};
        case (ctrl.memSize)
            SZ_BYTE: begin
                freshReq.sel  = 4'b0001 << addr[1:0];
                freshReq.datW = {4{storeData[7:0]}};
            end
            SZ_HALF: begin
                freshReq.sel  = addr[1] ? 4'b1100 : 4'b0011;
                freshReq.datW = {2{storeData[15:0]}};
            end
            default: begin
                freshReq.sel  = 4'b1111;
                freshReq.datW = storeData;
            end
        endcase
    end

    // first cycle drives straight from decode, later cycles replay the latch
    always_comb begin
        if (!rstN) begin
            wbReq = '0;
        end else if (state == WAIT) begin
            wbReq = reqQ;
        end else if (memOp) begin
            wbReq = freshReq;
        end else begin
            wbReq = '0;
        end
    end

    assign done = wbReq.stb & wbRsp.ack;

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            reqQ <= freshReq;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (wbReq.stb && !wbRsp.ack) state <= WAIT;
                default: if (wbRsp.ack) state <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // load lane select and sign extension
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (wbReq.sel)
            4'b0001: loadData = {{24{wbRsp.datR[7]}}, wbRsp.datR[7:0]};
            4'b0010: loadData = {{24{wbRsp.datR[15]}}, wbRsp.datR[15:8]};
            4'b0100: loadData = {{24{wbRsp.datR[23]}}, wbRsp.datR[23:16]};
            4'b1000: loadData = {{24{wbRsp.datR[31]}}, wbRsp.datR[31:24]};
            4'b0011: loadData = {{16{wbRsp.datR[15]}}, wbRsp.datR[15:0]};
            4'b1100: loadData = {{16{wbRsp.datR[31]}}, wbRsp.datR[31:16]};
            default: loadData = wbRsp.datR;
        endcase
    end

    aStbCyc: assert property (@(posedge clk) disable iff (!rstN)
        wbReq.stb |-> wbReq.cyc);

    // a stalled access keeps its request on the bus
    aAdrHold: assert property (@(posedge clk) disable iff (!rstN)
        (wbReq.stb && !wbRsp.ack) |=> (wbReq.stb && $stable(wbReq.adr)));

endmodule

//--- rtl/regFile.sv
`timescale 1ns/1ns

module regFile import mipsPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  rs,
    input  logic [4:0]  rt,
    output logic [31:0] rsData,
    output logic [31:0] rtData,
    input  logic        we,
    input  logic [4:0]  wAddr,
    input  logic [31:0] wData
);

    logic [XLEN-1:0] regs [REGS];

    // programs start from all-zero registers
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wAddr != 5'd0)) begin
            regs[wAddr] <= wData;
        end
    end

    // reads see the old value during a write cycle
    assign rsData = (rs == 5'd0) ? '0 : regs[rs];
    assign rtData = (rt == 5'd0) ? '0 : regs[rt];

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ns

module alu import mipsPkg::*; (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [4:0]  shamt,
    input  aluOpE       aluOp,
    output logic [31:0] result,
    output logic        zero,
    output logic        negA,
    output logic        zeroA
);

    logic [XLEN-1:0] diff;
    logic            lessThan;

    assign diff     = a - b;
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (aluOp)
            ALU_ADD:      result = a + b;
            ALU_SUB:      result = diff;
            // low word of the product only
            ALU_MUL:      result = a * b;
            ALU_AND:      result = a & b;
            ALU_OR:       result = a | b;
            ALU_NOR:      result = ~(a | b);
            ALU_XOR:      result = a ^ b;
            // shifts act on the rt operand
            ALU_SLL:      result = b << shamt;
            ALU_SRL:      result = b >> shamt;
            ALU_SLT:      result = {{(XLEN - 1){1'b0}}, lessThan};
            ALU_LUI_NONE: result = b;
            default:      result = '0;
        endcase
    end

    // equality for beq and bne
    assign zero = (diff == '0);

    // flags on rs alone for the compare-with-zero branches
    assign negA  = a[XLEN-1];
    assign zeroA = (a == '0);

endmodule

//--- rtl/controller.sv
`timescale 1ns/1ns

module controller import mipsPkg::*; (
    input  logic [5:0] op,
    input  logic [5:0] func,
    input  logic [4:0] rt,
    output ctrlT       ctrl
);

    // bundle that changes no state
    function automatic ctrlT nopCtrl(input logic bad);
        ctrlT c;
        c         = '0;
        c.aluOp   = ALU_LUI_NONE;
        c.immExt  = EXT_SIGN;
        c.memSize = SZ_WORD;
        c.branch  = BR_NONE;
        c.jump    = JMP_NONE;
        c.illegal = bad;
        return c;
    endfunction

    always_comb begin
        ctrl = nopCtrl(1'b0);
        case (opcodeE'(op))
            OP_RTYPE: begin
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                case (funcE'(func))
                    F_ADD: ctrl.aluOp = ALU_ADD;
                    F_SUB: ctrl.aluOp = ALU_SUB;
                    F_MUL: ctrl.aluOp = ALU_MUL;
                    F_AND: ctrl.aluOp = ALU_AND;
                    F_OR:  ctrl.aluOp = ALU_OR;
                    F_NOR: ctrl.aluOp = ALU_NOR;
                    F_XOR: ctrl.aluOp = ALU_XOR;
                    F_SLT: ctrl.aluOp = ALU_SLT;
                    F_SLL: begin
                        ctrl.aluOp        = ALU_SLL;
                        ctrl.shiftByShamt = 1'b1;
                    end
                    F_SRL: begin
                        ctrl.aluOp        = ALU_SRL;
                        ctrl.shiftByShamt = 1'b1;
                    end
                    F_JR: begin
                        ctrl.regWrite = 1'b0;
                        ctrl.jump     = JMP_REG;
                    end
                    default: ctrl = nopCtrl(1'b1);
                endcase
            end
            // bltz and bgez, told apart by rt
            OP_REGIMM: begin
                if (rt[4:1] == 4'b0000) begin
                    ctrl.aluOp  = ALU_SUB;
                    ctrl.branch = rt[0] ? BR_GEZ : BR_LTZ;
                end else begin
                    ctrl = nopCtrl(1'b1);
                end
            end
            OP_J: ctrl.jump = JMP_TARGET;
            OP_JAL: begin
                ctrl.jump     = JMP_TARGET;
                ctrl.link     = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
                ctrl.aluOp = ALU_SUB;
                case (opcodeE'(op))
                    OP_BEQ:  ctrl.branch = BR_EQ;
                    OP_BNE:  ctrl.branch = BR_NE;
                    OP_BLEZ: ctrl.branch = BR_LEZ;
                    default: ctrl.branch = BR_GTZ;
                endcase
            end
            OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
                case (opcodeE'(op))
                    OP_ADDI: ctrl.aluOp = ALU_ADD;
                    OP_SLTI: ctrl.aluOp = ALU_SLT;
                    OP_ANDI: ctrl.aluOp = ALU_AND;
                    OP_ORI:  ctrl.aluOp = ALU_OR;
                    default: ctrl.aluOp = ALU_XOR;
                endcase
                // logical immediates are zero extended
                if (ctrl.aluOp inside {ALU_AND, ALU_OR, ALU_XOR}) begin
                    ctrl.immExt = EXT_ZERO;
                end
            end
            OP_LB, OP_LH, OP_LW: begin
                ctrl.aluOp     = ALU_ADD;
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.memSize   = (opcodeE'(op) == OP_LB) ? SZ_BYTE :
                                 (opcodeE'(op) == OP_LH) ? SZ_HALF : SZ_WORD;
            end
            OP_SB, OP_SH, OP_SW: begin
                ctrl.aluOp     = ALU_ADD;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite  = 1'b1;
                ctrl.memSize   = (opcodeE'(op) == OP_SB) ? SZ_BYTE :
                                 (opcodeE'(op) == OP_SH) ? SZ_HALF : SZ_WORD;
            end
            default: ctrl = nopCtrl(1'b1);
        endcase
    end

    // a single bus access is either a read or a write
    always_comb begin
        assert (!(ctrl.memRead && ctrl.memWrite))
            else $error("controller: memRead and memWrite both set, op=%h", op);
    end

endmodule

//--- rtl/mipsPkg.sv
package mipsPkg;

    ////////////////////////////////////////////////////////////
    // core constants
    ////////////////////////////////////////////////////////////

    localparam int XLEN     = 32;
    localparam int REGS     = 32;
    localparam int LINK_REG = 31;
    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    ////////////////////////////////////////////////////////////
    // instruction encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        OP_RTYPE  = 6'b000000,
        OP_REGIMM = 6'b000001,
        OP_J      = 6'b000010,
        OP_JAL    = 6'b000011,
        OP_BEQ    = 6'b000100,
        OP_BNE    = 6'b000101,
        OP_BLEZ   = 6'b000110,
        OP_BGTZ   = 6'b000111,
        OP_ADDI   = 6'b001000,
        OP_SLTI   = 6'b001010,
        OP_ANDI   = 6'b001100,
        OP_ORI    = 6'b001101,
        OP_XORI   = 6'b001110,
        OP_LB     = 6'b100000,
        OP_LH     = 6'b100001,
        OP_LW     = 6'b100011,
        OP_SB     = 6'b101000,
        OP_SH     = 6'b101001,
        OP_SW     = 6'b101011
    } opcodeE;

    // function field of R-type words
    typedef enum logic [5:0] {
        F_SLL = 6'b000000,
        F_SRL = 6'b000010,
        F_JR  = 6'b001000,
        F_MUL = 6'b011000,
        F_ADD = 6'b100000,
        F_SUB = 6'b100010,
        F_AND = 6'b100100,
        F_OR  = 6'b100101,
        F_XOR = 6'b100110,
        F_NOR = 6'b100111,
        F_SLT = 6'b101010
    } funcE;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_MUL,
        ALU_AND,
        ALU_OR,
        ALU_NOR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT,
        ALU_LUI_NONE
    } aluOpE;

    typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_GTZ, BR_LEZ, BR_GEZ, BR_LTZ} branchE;
    typedef enum logic [1:0] {JMP_NONE, JMP_TARGET, JMP_REG} jumpE;
    typedef enum logic [1:0] {SZ_BYTE, SZ_HALF, SZ_WORD} memSizeE;
    typedef enum logic {EXT_SIGN, EXT_ZERO} immExtE;

    ////////////////////////////////////////////////////////////
    // bundles
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        aluOpE    aluOp;
        logic     aluSrcImm;
        logic     shiftByShamt;
        immExtE   immExt;
        logic     regDst;       // 1 selects rd, 0 selects rt
        logic     regWrite;
        logic     memToReg;
        logic     memRead;
        logic     memWrite;
        memSizeE  memSize;
        branchE   branch;
        jumpE     jump;
        logic     link;
        logic     illegal;
    } ctrlT;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] datW;
    } wbReqT;

    typedef struct packed {
        logic        ack;
        logic [31:0] datR;
    } wbRspT;

endpackage
